/* src/mips_pkg.sv */
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // Operand source select for the execute stage
  typedef logic [1:0]  fwd_sel_t;

  localparam fwd_sel_t FWD_REG = 2'd0;
  localparam fwd_sel_t FWD_WB  = 2'd1;
  localparam fwd_sel_t FWD_MEM = 2'd2;

  // ------------------------------
  // Opcodes and R-type funct codes
  // ------------------------------
  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_LW    = 6'b100011;
  localparam logic [5:0] OP_SW    = 6'b101011;
  localparam logic [5:0] OP_BEQ   = 6'b000100;
  localparam logic [5:0] OP_ADDI  = 6'b001000;

  localparam logic [5:0] FUNCT_ADD = 6'b100000;
  localparam logic [5:0] FUNCT_SUB = 6'b100010;
  localparam logic [5:0] FUNCT_AND = 6'b100100;
  localparam logic [5:0] FUNCT_OR  = 6'b100101;
  localparam logic [5:0] FUNCT_SLT = 6'b101010;

  // Classic MIPS ALU control encoding
  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } alu_op_t;

  // ------------------------------
  // Pipeline stage bundles
  // ------------------------------
  // All zero is a bubble
  typedef struct packed {
    logic    reg_write;
    logic    mem_to_reg;
    logic    mem_write;
    logic    mem_read;
    logic    branch;
    logic    alu_src;
    logic    reg_dst;
    alu_op_t alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     pc_plus4;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
  } id_ex_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;
    logic      mem_write;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t dest;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    logic      mem_to_reg;
    word_t     alu_result;
    word_t     read_data;
    reg_addr_t dest;
  } mem_wb_t;

endpackage

/* src/mips_decoder.sv */
module mips_decoder import mips_pkg::*; (
  input  logic [5:0] opcode,
  input  logic [5:0] funct,
  output ctrl_t      ctrl
);

  alu_op_t rtype_op;
  logic    rtype_valid;

  // ALU decoder for R-type funct field
  always_comb begin
    rtype_valid = 1'b1;
    case (funct)
      FUNCT_ADD: rtype_op = ALU_ADD;
      FUNCT_SUB: rtype_op = ALU_SUB;
      FUNCT_AND: rtype_op = ALU_AND;
      FUNCT_OR:  rtype_op = ALU_OR;
      FUNCT_SLT: rtype_op = ALU_SLT;
      default: begin
        rtype_op    = ALU_AND;
        rtype_valid = 1'b0;
      end
    endcase
  end

  // Main decoder
  always_comb begin
    ctrl = '0;
    case (opcode)
      OP_RTYPE: begin
        // Unknown funct, including the all-zero nop, stays a bubble
        if (rtype_valid) begin
          ctrl.reg_write = 1'b1;
          ctrl.reg_dst   = 1'b1;
          ctrl.alu_op    = rtype_op;
        end
      end
      OP_LW: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.alu_op     = ALU_ADD;
      end
      OP_SW: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      OP_BEQ: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_SUB;
      end
      OP_ADDI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = ALU_ADD;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

/* src/mips_regfile.sv */
module mips_regfile import mips_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  input  reg_addr_t wa,
  input  logic      we,
  input  word_t     wd,
  output word_t     rd1,
  output word_t     rd2
);

  word_t regs [32];
  logic  wr_live;

  // Register 0 is never written, so it keeps the zero from reset
  assign wr_live = we && (wa != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wa] <= wd;
    end
  end

  // Write-through so decode sees the write-back value in the same cycle
  assign rd1 = (wr_live && wa == ra1) ? wd : regs[ra1];
  assign rd2 = (wr_live && wa == ra2) ? wd : regs[ra2];

  a_zero_reg_rd1: assert property (@(posedge clk) disable iff (reset)
    (ra1 == '0) |-> (rd1 == '0));
  a_zero_reg_rd2: assert property (@(posedge clk) disable iff (reset)
    (ra2 == '0) |-> (rd2 == '0));

endmodule

/* src/mips_hazard_unit.sv */
module mips_hazard_unit import mips_pkg::*; (
  input  word_t    if_id_instr,
  input  id_ex_t   id_ex,
  input  ex_mem_t  ex_mem,
  input  mem_wb_t  mem_wb,
  input  logic     branch_taken,
  output logic     stall,
  output logic     flush,
  output fwd_sel_t fwd_a,
  output fwd_sel_t fwd_b
);

  reg_addr_t id_rs;
  reg_addr_t id_rt;

  // Memory stage holds the newer value, so it wins over write-back
  function automatic fwd_sel_t pick_fwd(reg_addr_t src, ex_mem_t em, mem_wb_t mw);
    fwd_sel_t sel;
    sel = FWD_REG;
    if (mw.reg_write && mw.dest != '0 && mw.dest == src) begin
      sel = FWD_WB;
    end
    if (em.reg_write && em.dest != '0 && em.dest == src) begin
      sel = FWD_MEM;
    end
    return sel;
  endfunction

  assign id_rs = if_id_instr[25:21];
  assign id_rt = if_id_instr[20:16];

  assign fwd_a = pick_fwd(id_ex.rs, ex_mem, mem_wb);
  assign fwd_b = pick_fwd(id_ex.rt, ex_mem, mem_wb);

  // Load in execute feeding the instruction in decode
  assign stall = id_ex.ctrl.mem_read && (id_ex.rt != '0) &&
                 (id_ex.rt == id_rs || id_ex.rt == id_rt);

  assign flush = branch_taken;

  // A load and a branch cannot sit in execute at once
  always_comb begin
    a_no_stall_flush: assert (!(stall === 1'b1 && flush === 1'b1))
      else $error("stall and flush raised together");
  end

endmodule

/* src/mips_fetch.sv */
module mips_fetch import mips_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  reset,
  input  word_t instr,
  input  logic  stall,
  input  logic  flush,
  input  logic  branch_taken,
  input  word_t branch_target,
  output word_t pc,
  output word_t if_id_instr,
  output word_t if_id_pc_plus4
);

  word_t pc_plus4;

  assign pc_plus4 = pc + 32'd4;

  // Branch redirect has priority; stall holds the PC
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc_plus4;
    end
  end

  // ------------------------------
  // IF/ID register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      if_id_instr <= '0;
    end else if (!stall) begin
      if_id_instr <= instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      if_id_pc_plus4 <= pc_plus4;
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

/* src/mips_decode.sv */
module mips_decode import mips_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  word_t     if_id_instr,
  input  word_t     if_id_pc_plus4,
  input  logic      stall,
  input  logic      flush,
  input  logic      wb_we,
  input  reg_addr_t wb_addr,
  input  word_t     wb_data,
  output id_ex_t    id_ex
);

  ctrl_t  dec_ctrl;
  word_t  rs_data;
  word_t  rt_data;
  id_ex_t id_ex_next;

  mips_regfile u_regfile (
    .clk   (clk),
    .reset (reset),
    .ra1   (if_id_instr[25:21]),
    .ra2   (if_id_instr[20:16]),
    .wa    (wb_addr),
    .we    (wb_we),
    .wd    (wb_data),
    .rd1   (rs_data),
    .rd2   (rt_data)
  );

  mips_decoder u_decoder (
    .opcode (if_id_instr[31:26]),
    .funct  (if_id_instr[5:0]),
    .ctrl   (dec_ctrl)
  );

  always_comb begin
    id_ex_next.ctrl     = (stall || flush) ? ctrl_t'('0) : dec_ctrl;
    id_ex_next.pc_plus4 = if_id_pc_plus4;
    id_ex_next.rs_data  = rs_data;
    id_ex_next.rt_data  = rt_data;
    // Sign-extended immediate
    id_ex_next.imm      = {{16{if_id_instr[15]}}, if_id_instr[15:0]};
    id_ex_next.rs       = if_id_instr[25:21];
    id_ex_next.rt       = if_id_instr[20:16];
    id_ex_next.rd       = if_id_instr[15:11];
  end

  // ------------------------------
  // ID/EX register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.ctrl <= '0;
    end else begin
      id_ex <= id_ex_next;
    end
  end

endmodule

/* src/mips_execute.sv */
module mips_execute import mips_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  id_ex_t   id_ex,
  input  fwd_sel_t fwd_a,
  input  fwd_sel_t fwd_b,
  input  word_t    mem_wb_result,
  output ex_mem_t  ex_mem,
  output logic     branch_taken,
  output word_t    branch_target
);

  word_t     src_a;
  word_t     fwd_b_data;
  word_t     src_b;
  word_t     alu_y;
  reg_addr_t dest;

  function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t wb_val,
                                    word_t mem_val);
    word_t y;
    case (sel)
      FWD_MEM: y = mem_val;
      FWD_WB:  y = wb_val;
      default: y = reg_val;
    endcase
    return y;
  endfunction

  // ------------------------------
  // Operand forwarding
  // ------------------------------
  assign src_a      = fwd_mux(fwd_a, id_ex.rs_data, mem_wb_result, ex_mem.alu_result);
  assign fwd_b_data = fwd_mux(fwd_b, id_ex.rt_data, mem_wb_result, ex_mem.alu_result);
  assign src_b      = id_ex.ctrl.alu_src ? id_ex.imm : fwd_b_data;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD: alu_y = src_a + src_b;
      ALU_SUB: alu_y = src_a - src_b;
      ALU_AND: alu_y = src_a & src_b;
      ALU_OR:  alu_y = src_a | src_b;
      ALU_SLT: alu_y = {31'b0, $signed(src_a) < $signed(src_b)};
      default: alu_y = '0;
    endcase
  end

  assign dest = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;

  // A beq subtracts so equal operands give zero
  assign branch_target = id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};
  assign branch_taken  = id_ex.ctrl.branch && (alu_y == '0);

  // ------------------------------
  // EX/MEM register
  // ------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.reg_write  <= 1'b0;
      ex_mem.mem_to_reg <= 1'b0;
      ex_mem.mem_write  <= 1'b0;
    end else begin
      ex_mem.reg_write  <= id_ex.ctrl.reg_write;
      ex_mem.mem_to_reg <= id_ex.ctrl.mem_to_reg;
      ex_mem.mem_write  <= id_ex.ctrl.mem_write;
      ex_mem.alu_result <= alu_y;
      ex_mem.store_data <= fwd_b_data;
      ex_mem.dest       <= dest;
    end
  end

endmodule

/* src/mips_mem_wb.sv */
module mips_mem_wb import mips_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  ex_mem_t ex_mem,
  input  word_t   mem_read_data,
  output mem_wb_t mem_wb,
  output word_t   wb_data
);

  // MEM/WB register
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.reg_write  <= 1'b0;
      mem_wb.mem_to_reg <= 1'b0;
    end else begin
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.mem_to_reg <= ex_mem.mem_to_reg;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.read_data  <= mem_read_data;
      mem_wb.dest       <= ex_mem.dest;
    end
  end

  // Load data or ALU result
  assign wb_data = mem_wb.mem_to_reg ? mem_wb.read_data : mem_wb.alu_result;

endmodule

/* src/mips_core.sv */
module mips_core import mips_pkg::*; #(
  parameter word_t RESET_PC = 32'h0000_0000
) (
  input  logic  clk,
  input  logic  reset,
  input  word_t instr,
  input  word_t mem_read_data,
  output word_t pc,
  output logic  mem_write,
  output word_t mem_addr,
  output word_t mem_write_data
);

  word_t    if_id_instr;
  word_t    if_id_pc_plus4;
  id_ex_t   id_ex;
  ex_mem_t  ex_mem;
  mem_wb_t  mem_wb;
  word_t    wb_data;
  logic     stall;
  logic     flush;
  fwd_sel_t fwd_a;
  fwd_sel_t fwd_b;
  logic     branch_taken;
  word_t    branch_target;

  mips_fetch #(
    .RESET_PC (RESET_PC)
  ) u_fetch (
    .clk            (clk),
    .reset          (reset),
    .instr          (instr),
    .stall          (stall),
    .flush          (flush),
    .branch_taken   (branch_taken),
    .branch_target  (branch_target),
    .pc             (pc),
    .if_id_instr    (if_id_instr),
    .if_id_pc_plus4 (if_id_pc_plus4)
  );

  mips_decode u_decode (
    .clk            (clk),
    .reset          (reset),
    .if_id_instr    (if_id_instr),
    .if_id_pc_plus4 (if_id_pc_plus4),
    .stall          (stall),
    .flush          (flush),
    .wb_we          (mem_wb.reg_write),
    .wb_addr        (mem_wb.dest),
    .wb_data        (wb_data),
    .id_ex          (id_ex)
  );

  mips_execute u_execute (
    .clk           (clk),
    .reset         (reset),
    .id_ex         (id_ex),
    .fwd_a         (fwd_a),
    .fwd_b         (fwd_b),
    .mem_wb_result (wb_data),
    .ex_mem        (ex_mem),
    .branch_taken  (branch_taken),
    .branch_target (branch_target)
  );

  mips_mem_wb u_mem_wb (
    .clk           (clk),
    .reset         (reset),
    .ex_mem        (ex_mem),
    .mem_read_data (mem_read_data),
    .mem_wb        (mem_wb),
    .wb_data       (wb_data)
  );

  mips_hazard_unit u_hazard_unit (
    .if_id_instr  (if_id_instr),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .mem_wb       (mem_wb),
    .branch_taken (branch_taken),
    .stall        (stall),
    .flush        (flush),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b)
  );

  // Data port is driven straight from the memory stage
  assign mem_addr       = ex_mem.alu_result;
  assign mem_write      = ex_mem.mem_write;
  assign mem_write_data = ex_mem.store_data;

endmodule

/* tests/tb_mips.sv */
module tb_mips import mips_pkg::*; ();

  localparam word_t RESET_PC      = 32'h0000_0080;
  localparam int    MEM_WORDS     = 64;
  localparam int    STORE_TIMEOUT = 40;
  localparam int    TAIL_CYCLES   = 30;

  logic  clk;
  logic  reset;
  word_t instr;
  word_t mem_read_data;
  word_t pc;
  logic  mem_write;
  word_t mem_addr;
  word_t mem_write_data;

  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  word_t exp_addr [$];
  word_t exp_data [$];

  int value_errors;
  int timeout_errors;
  int other_errors;
  int cur_store;

  mips_core #(
    .RESET_PC (RESET_PC)
  ) u_mips_core (
    .clk            (clk),
    .reset          (reset),
    .instr          (instr),
    .mem_read_data  (mem_read_data),
    .pc             (pc),
    .mem_write      (mem_write),
    .mem_addr       (mem_addr),
    .mem_write_data (mem_write_data)
  );

  always #2 clk = ~clk;

  // ------------------------------
  // Memory models
  // ------------------------------
  // Words outside the program read as nop
  function automatic word_t fetch_word(word_t addr);
    word_t offset;
    offset = addr - RESET_PC;
    if (offset < word_t'(MEM_WORDS * 4)) begin
      return imem[offset[7:2]];
    end
    return '0;
  endfunction

  always @(negedge clk) begin
    instr         = fetch_word(pc);
    mem_read_data = dmem[mem_addr[7:2]];
  end

  always @(posedge clk) begin
    if (mem_write) begin
      dmem[mem_addr[7:2]] = mem_write_data;
    end
  end

  // ------------------------------
  // Data file and checks
  // ------------------------------
  task automatic load_testdata();
    int                 fd;
    int                 n;
    int                 word_idx;
    logic               done;
    logic [7:0]         tag;
    word_t              a;
    word_t              d;
    logic [8*128-1:0]   rest;
    word_idx = 0;
    done     = 1'b0;
    fd = $fopen("tests/mips_testdata.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open tests/mips_testdata.txt");
      done = 1'b1;
    end
    while (!done) begin
      n = $fscanf(fd, " %c", tag);
      if (n != 1) begin
        done = 1'b1;
      end else begin
        case (tag)
          "I": begin
            n = $fscanf(fd, "%h", d);
            if (word_idx < MEM_WORDS) begin
              imem[word_idx[5:0]] = d;
            end else begin
              other_errors++;
              $display("Program in the data file is larger than the instruction memory");
            end
            word_idx++;
          end
          "D": begin
            n = $fscanf(fd, "%h %h", a, d);
            dmem[a[7:2]] = d;
          end
          "S": begin
            n = $fscanf(fd, "%h %h", a, d);
            exp_addr.push_back(a);
            exp_data.push_back(d);
          end
          "#": ;
          default: begin
            other_errors++;
            $display("Unknown line tag %c in the data file", tag);
          end
        endcase
        // Rest of the line is a comment
        n = $fgets(rest, fd);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
  endtask

  task automatic check_pc(input word_t expected);
    if (pc !== expected) begin
      value_errors++;
      $display("ERROR at %0t: pc is %h, expected %h", $time, pc, expected);
    end
  endtask

  task automatic check_store(input word_t address, input word_t data);
    if (mem_addr !== address) begin
      value_errors++;
      $display("ERROR at %0t: store %0d address is %h, expected %h",
               $time, cur_store, mem_addr, address);
    end
    if (mem_write_data !== data) begin
      value_errors++;
      $display("ERROR at %0t: store %0d data is %h, expected %h",
               $time, cur_store, mem_write_data, data);
    end
  endtask

  // Next store seen on the data port must be store k
  task automatic await_store(input int k);
    int   cycles;
    logic seen;
    cycles    = 0;
    seen      = 1'b0;
    cur_store = k;
    while (!seen && cycles < STORE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (mem_write) begin
        check_store(exp_addr[k], exp_data[k]);
        seen = 1'b1;
      end
    end
    if (!seen) begin
      timeout_errors++;
      $display("Store %0d to address %h never arrived within %0d cycles",
               k, exp_addr[k], STORE_TIMEOUT);
    end
  endtask

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    instr          = '0;
    mem_read_data  = '0;
    value_errors   = 0;
    timeout_errors = 0;
    other_errors   = 0;
    cur_store      = 0;
    imem = '{default: '0};
    dmem = '{default: '0};
    load_testdata();
    if (exp_addr.size() == 0) begin
      other_errors++;
      $display("The data file lists no expected stores");
    end

    repeat (4) begin
      @(negedge clk);
      if (mem_write === 1'b1) begin
        other_errors++;
        $display("A store was issued while reset was asserted");
      end
    end
    reset = 1'b0;
    check_pc(RESET_PC);

    for (int k = 0; k < exp_addr.size(); k++) begin
      await_store(k);
    end

    // Skipped or extra stores would show up here
    repeat (TAIL_CYCLES) begin
      @(negedge clk);
      if (mem_write) begin
        other_errors++;
        $display("Unexpected store to address %h after the last expected store", mem_addr);
      end
    end

    $display("Errors: %0d value, %0d timeout, %0d other",
             value_errors, timeout_errors, other_errors);
    if (value_errors + timeout_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* tests/mips_testdata.txt */
# I <instruction hex> placed at consecutive words from the reset PC
# D <address hex> <initial data hex>, S <address hex> <data hex> expected store in program order
I 20010005  # addi $1, $0, 5
I 2002000E  # addi $2, $0, 14
I 00221820  # add  $3, $1, $2      = 19
I AC030000  # sw   $3, 0($0)
I 00612022  # sub  $4, $3, $1      = 14
I 00832824  # and  $5, $4, $3      = 2
I 00A13025  # or   $6, $5, $1      = 7
I AC040004  # sw   $4, 4($0)
I AC050008  # sw   $5, 8($0)
I AC06000C  # sw   $6, 12($0)
I 2008FFFD  # addi $8, $0, -3
I 0101482A  # slt  $9, $8, $1      = 1
I 01285020  # add  $10, $9, $8     = -2
I AC090010  # sw   $9, 16($0)
I AC0A0014  # sw   $10, 20($0)
I 8C0B00C0  # lw   $11, 0xC0($0)
I 01616020  # add  $12, $11, $1    load-use
I AC0C0018  # sw   $12, 24($0)
I 8C0D0000  # lw   $13, 0($0)      reads the first store
I AC0D001C  # sw   $13, 28($0)     load-use on store data
I 200E0013  # addi $14, $0, 19
I 11C30002  # beq  $14, $3, +2     taken
I AC010020  # sw   $1, 32($0)      skipped
I 20010063  # addi $1, $0, 99      skipped
I AC010024  # sw   $1, 36($0)
I 10220001  # beq  $1, $2, +1      not taken
I AC020028  # sw   $2, 40($0)
I 200F007F  # addi $15, $0, 0x7F
I AC0F002C  # sw   $15, 44($0)
D 00000000 55555555
D 000000C0 00000123
S 00000000 00000013
S 00000004 0000000E
S 00000008 00000002
S 0000000C 00000007
S 00000010 00000001
S 00000014 FFFFFFFE
S 00000018 00000128
S 0000001C 00000013
S 00000024 00000005
S 00000028 0000000E
S 0000002C 0000007F

/* verilog.f */
src/mips_pkg.sv
src/mips_decoder.sv
src/mips_regfile.sv
src/mips_hazard_unit.sv
src/mips_fetch.sv
src/mips_decode.sv
src/mips_execute.sv
src/mips_mem_wb.sv
src/mips_core.sv
tests/tb_mips.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_mips
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
